//--- tb.f
+incdir+verif
design/batchPkg.sv
design/sampleStore.sv
design/contribLane.sv
design/contribSum.sv
design/recursionCore.sv
design/batchEstimator.sv
verif/batchEstimatorTb.sv

//--- Bender.yml
package:
  name: batch_estimator

sources:
  - files:
      - design/batchPkg.sv
      - design/sampleStore.sv
      - design/contribLane.sv
      - design/contribSum.sv
      - design/recursionCore.sv
      - design/batchEstimator.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/batchEstimatorTb.sv

//--- verif/batchEstimatorTests.svh
// Power-on reset, then random words through the warm-up window
task automatic resetWarmup();
    startTest();
    applyReset();
    repeat (WarmWords) begin
        driveCycle(wordT'(nextRandom()));
    end
    flushPipeline();
    reportTest("reset and warm-up");
endtask

// Every bit clear, forward state carried over batch boundaries
task automatic zeroWords();
    startTest();
    alignBatch();
    repeat (ZeroWords) begin
        driveCycle('0);
    end
    flushPipeline();
    reportTest("all-zero words");
endtask

// One set bit per batch, moving through the batch positions
task automatic impulseSweep();
    startTest();
    alignBatch();
    for (int i = 0; i < ImpulseBatches; i++) begin
        for (int p = 0; p < BatchDepth; p++) begin
            if (p == i % BatchDepth) begin
                driveCycle(wordT'(1) << ((3 * i + 1) % WordBits));
            end else begin
                driveCycle('0);
            end
        end
    end
    flushPipeline();
    reportTest("impulse sweep");
endtask

task automatic randomStream();
    startTest();
    repeat (RandomWords) begin
        driveCycle(wordT'(nextRandom()));
    end
    flushPipeline();
    reportTest("random words");
endtask

// Forward plus backward exceeds the output range near batch start
task automatic onesSaturate();
    startTest();
    satHits = 0;
    alignBatch();
    repeat (OnesWords) begin
        driveCycle('1);
    end
    flushPipeline();
    if (satHits == 0) begin
        failCount++;
        $display("All-ones run never produced the saturated full-scale code");
    end
    reportTest("all-ones saturation");
endtask

task automatic midStreamReset();
    startTest();
    repeat (PreResetWords) begin
        driveCycle(wordT'(nextRandom()));
    end
    // Valid must drop at the first check after reset goes low
    applyReset();
    repeat (PostResetWords) begin
        driveCycle(wordT'(nextRandom()));
    end
    flushPipeline();
    reportTest("mid-stream reset");
endtask

//--- verif/batchEstimatorTb.sv
module batchEstimatorTb import batchPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ResetCycles = 10;
    localparam int WarmWords = LatencyCycles + BatchDepth;
    localparam int ZeroWords = 6 * BatchDepth;
    localparam int ImpulseBatches = 8;
    localparam int RandomWords = 20 * BatchDepth;
    localparam int OnesWords = 6 * BatchDepth;
    localparam int PreResetWords = 2 * BatchDepth;
    localparam int PostResetWords = LatencyCycles + 2 * BatchDepth;
    localparam int NumTests = 6;
    // Every test flushes the pipeline and may pad up to one batch
    localparam int TestCycles = 2 * (ResetCycles + 1) + WarmWords + ZeroWords
        + ImpulseBatches * BatchDepth + RandomWords + OnesWords + PreResetWords
        + PostResetWords + NumTests * (LatencyCycles + BatchDepth);
    localparam int CycleLimit = TestCycles + LatencyCycles + 100;

    logic clkDS = 1'b0;
    logic rst;
    wordT sampleWord;
    outT  estimate;
    logic estimateValid;

    // Reference model state with word 0 latched at the first edge
    wordT        modelWords [$];
    int          fwdModel = 0;
    int          fwdIndex = 0;
    int          edgeCount = 0;
    int          cycleCount = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          testPassBase = 0;
    int          testFailBase = 0;
    int          satHits = 0;
    logic [31:0] rngState = 32'hca96_4600;

    always #4 clkDS = ~clkDS;

    batchEstimator i_batchEstimator (
        .clkDS         (clkDS),
        .rst           (rst),
        .sampleWord    (sampleWord),
        .estimate      (estimate),
        .estimateValid (estimateValid)
    );

    // Run guard
    always @(posedge clkDS) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("Run timed out after %0d cycles before the tests finished", cycleCount);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Each control bit adds its weight when set and subtracts it when clear
    function automatic int contribution(input wordT w, input bit backward);
        int sum;
        int wt;
        sum = 0;
        for (int b = 0; b < WordBits; b++) begin
            wt = backward ? int'(bwdWeight[b]) : int'(fwdWeight[b]);
            sum = w[b] ? sum + wt : sum - wt;
        end
        return sum;
    endfunction

    function automatic outT expectedEstimate(input int s);
        int   last;
        int   bwd;
        int   sum;
        outT  coded;
        // Forward state runs in sample order across batches
        while (fwdIndex <= s) begin
            fwdModel = fwdModel - (fwdModel >>> DecayShift)
                     + contribution(modelWords[fwdIndex], 1'b0);
            fwdIndex++;
        end
        // Backward state restarts at the last word of the batch
        last = (s / BatchDepth) * BatchDepth + BatchDepth - 1;
        bwd = 0;
        for (int j = last; j >= s; j--) begin
            if (j == last) begin
                bwd = contribution(modelWords[j], 1'b1);
            end else begin
                bwd = bwd - (bwd >>> DecayShift) + contribution(modelWords[j], 1'b1);
            end
        end
        sum = fwdModel + bwd;
        if (sum > OutMax) begin
            sum = OutMax;
        end else if (sum < OutMin) begin
            sum = OutMin;
        end
        coded = outT'(sum);
        coded[OutBits-1] = ~coded[OutBits-1];
        return coded;
    endfunction

    task automatic compareEstimate(input outT got, input outT exp, input string what);
        if (got !== exp) begin
            failCount++;
            $display("Error at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        end else begin
            passCount++;
        end
    endtask

    task automatic compareValid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            failCount++;
            $display("Error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
        end else begin
            passCount++;
        end
    endtask

    // Outputs sampled at the falling edge once settled
    task automatic checkOutputs();
        outT exp;
        int  s;
        s = edgeCount - LatencyCycles;
        if (s >= 0) begin
            exp = expectedEstimate(s);
            compareValid(estimateValid, 1'b1, "estimateValid after warm-up");
            compareEstimate(estimate, exp, $sformatf("estimate for sample %0d", s));
            if (exp == '1) begin
                satHits++;
            end
        end else begin
            compareValid(estimateValid, 1'b0, "estimateValid during warm-up");
            compareEstimate(estimate, '0, "estimate while invalid");
        end
    endtask

    task automatic driveCycle(input wordT w);
        @(posedge clkDS);
        sampleWord <= w;
        // Latched by the DUT at the next edge
        modelWords.push_back(w);
        edgeCount++;
        @(negedge clkDS);
        checkOutputs();
    endtask

    task automatic applyReset();
        @(posedge clkDS);
        rst <= 1'b0;
        sampleWord <= '0;
        repeat (ResetCycles) begin
            @(negedge clkDS);
            compareValid(estimateValid, 1'b0, "estimateValid in reset");
            compareEstimate(estimate, '0, "estimate in reset");
            @(posedge clkDS);
        end
        rst <= 1'b1;
        // Model restarts from zero with the held zero as its first word
        modelWords.delete();
        modelWords.push_back('0);
        fwdModel = 0;
        fwdIndex = 0;
        edgeCount = 0;
    endtask

    task automatic alignBatch();
        while ((edgeCount + 1) % BatchDepth != 0) begin
            driveCycle('0);
        end
    endtask

    task automatic flushPipeline();
        repeat (LatencyCycles) begin
            driveCycle('0);
        end
    endtask

    task automatic startTest();
        testPassBase = passCount;
        testFailBase = failCount;
    endtask

    task automatic reportTest(input string name);
        $display("Test %s done: %0d checks passed, %0d failed", name,
                 passCount - testPassBase, failCount - testFailBase);
    endtask

    `include "batchEstimatorTests.svh"

    initial begin
        rst = 1'b0;
        sampleWord = '0;
        resetWarmup();
        zeroWords();
        impulseSweep();
        randomStream();
        onesSaturate();
        midStreamReset();
        $display("Summary: %0d checks passed, %0d checks failed", passCount, failCount);
        if (failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- design/batchEstimator.sv
module batchEstimator import batchPkg::*; (
    input  logic clkDS,
    input  logic rst,
    input  wordT sampleWord,
    output outT  estimate,
    output logic estimateValid
);

    wordT     fwdWord;
    wordT     bwdWord;
    posT      fwdPos;
    posT      bwdPos;
    batchIdxT fwdBatch;
    batchIdxT bwdBatch;
    logic     bwdFirst;
    logic     fwdLive;
    laneT     fwdParts [NumLanes];
    laneT     bwdParts [NumLanes];
    contribT  fwdContrib;
    contribT  bwdContrib;

    sampleStore i_sampleStore (
        .clkDS      (clkDS),
        .rst        (rst),
        .sampleWord (sampleWord),
        .fwdWord    (fwdWord),
        .bwdWord    (bwdWord),
        .fwdPos     (fwdPos),
        .bwdPos     (bwdPos),
        .fwdBatch   (fwdBatch),
        .bwdBatch   (bwdBatch),
        .bwdFirst   (bwdFirst),
        .fwdLive    (fwdLive)
    );

    // One lane per 4-bit slice of both read words
    for (genvar k = 0; k < NumLanes; k++) begin : genLane
        contribLane #(.laneIdx(k)) i_contribLane (
            .clkDS   (clkDS),
            .rst     (rst),
            .fwdBits (fwdWord[k*LaneBits +: LaneBits]),
            .bwdBits (bwdWord[k*LaneBits +: LaneBits]),
            .fwdPart (fwdParts[k]),
            .bwdPart (bwdParts[k])
        );
    end

    contribSum i_contribSum (
        .clkDS      (clkDS),
        .rst        (rst),
        .fwdParts   (fwdParts),
        .bwdParts   (bwdParts),
        .fwdContrib (fwdContrib),
        .bwdContrib (bwdContrib)
    );

    recursionCore i_recursionCore (
        .clkDS         (clkDS),
        .rst           (rst),
        .fwdContrib    (fwdContrib),
        .bwdContrib    (bwdContrib),
        .fwdPos        (fwdPos),
        .bwdPos        (bwdPos),
        .fwdBatch      (fwdBatch),
        .bwdBatch      (bwdBatch),
        .bwdFirst      (bwdFirst),
        .fwdLive       (fwdLive),
        .estimate      (estimate),
        .estimateValid (estimateValid)
    );

endmodule

//--- design/recursionCore.sv
module recursionCore import batchPkg::*; (
    input  logic     clkDS,
    input  logic     rst,
    input  contribT  fwdContrib,
    input  contribT  bwdContrib,
    input  posT      fwdPos,
    input  posT      bwdPos,
    input  batchIdxT fwdBatch,
    input  batchIdxT bwdBatch,
    input  logic     bwdFirst,
    input  logic     fwdLive,
    output outT      estimate,
    output logic     estimateValid
);

    posT      fwdPosQ [PipeDelay];
    posT      bwdPosQ [PipeDelay];
    batchIdxT fwdBatchQ [PipeDelay];
    batchIdxT bwdBatchQ [PipeDelay];
    logic     bwdFirstQ [PipeDelay];
    logic     fwdLiveQ [PipeDelay];

    stateT bwdMem [NumSlots*BatchDepth];
    stateT bwdState;
    stateT bwdNext;
    stateT fwdState;
    stateT fwdNext;
    stateT bwdRead;
    logic  stateLive;

    logic signed [StateBits:0]   sumWide;
    logic signed [OutBits-1:0]   satSum;

    // Side-band delay to meet the lane and adder latency
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            fwdPosQ   <= '{default: '0};
            bwdPosQ   <= '{default: '0};
            fwdBatchQ <= '{default: '0};
            bwdBatchQ <= '{default: '0};
            bwdFirstQ <= '{default: 1'b0};
            fwdLiveQ  <= '{default: 1'b0};
        end else begin
            fwdPosQ[0]   <= fwdPos;
            bwdPosQ[0]   <= bwdPos;
            fwdBatchQ[0] <= fwdBatch;
            bwdBatchQ[0] <= bwdBatch;
            bwdFirstQ[0] <= bwdFirst;
            fwdLiveQ[0]  <= fwdLive;
            for (int i = 1; i < PipeDelay; i++) begin
                fwdPosQ[i]   <= fwdPosQ[i-1];
                bwdPosQ[i]   <= bwdPosQ[i-1];
                fwdBatchQ[i] <= fwdBatchQ[i-1];
                bwdBatchQ[i] <= bwdBatchQ[i-1];
                bwdFirstQ[i] <= bwdFirstQ[i-1];
                fwdLiveQ[i]  <= fwdLiveQ[i-1];
            end
        end
    end

    // Backward restarts from zero on the first reversed word of a batch
    assign bwdNext = bwdFirstQ[PipeDelay-1] ? stateT'(bwdContrib)
                   : bwdState - (bwdState >>> DecayShift) + stateT'(bwdContrib);
    assign fwdNext = fwdState - (fwdState >>> DecayShift) + stateT'(fwdContrib);

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            bwdState  <= '0;
            fwdState  <= '0;
            stateLive <= 1'b0;
        end else begin
            bwdState  <= bwdNext;
            fwdState  <= fwdLiveQ[PipeDelay-1] ? fwdNext : '0;
            stateLive <= fwdLiveQ[PipeDelay-1];
        end
    end

    // Backward results stored by sample slot and read back in forward order
    always_ff @(posedge clkDS) begin
        bwdMem[{bwdBatchQ[PipeDelay-1], bwdPosQ[PipeDelay-1]}] <= bwdNext;
        bwdRead <= bwdMem[{fwdBatchQ[PipeDelay-1], fwdPosQ[PipeDelay-1]}];
    end

    // Combine and clamp to the signed output range
    always_comb begin
        sumWide = fwdState + bwdRead;
        if (sumWide > OutMax) begin
            satSum = OutBits'(OutMax);
        end else if (sumWide < OutMin) begin
            satSum = OutBits'(OutMin);
        end else begin
            satSum = sumWide[OutBits-1:0];
        end
    end

    // Offset binary output held at zero until the first live sample
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            estimate      <= '0;
            estimateValid <= 1'b0;
        end else begin
            estimate      <= stateLive ? {~satSum[OutBits-1], satSum[OutBits-2:0]} : '0;
            estimateValid <= stateLive;
        end
    end

    validHolds: assert property (
        @(posedge clkDS) disable iff (!rst)
        !$fell(estimateValid)
    ) else $error("recursionCore: estimateValid dropped without reset");

    fwdIdleZero: assert property (
        @(posedge clkDS) disable iff (!rst)
        !fwdLive |-> (fwdState == '0)
    ) else $error("recursionCore: forward state nonzero before warm-up");

endmodule

//--- design/contribSum.sv
module contribSum import batchPkg::*; (
    input  logic    clkDS,
    input  logic    rst,
    input  laneT    fwdParts [NumLanes],
    input  laneT    bwdParts [NumLanes],
    output contribT fwdContrib,
    output contribT bwdContrib
);

    contribT fwdTotal;
    contribT bwdTotal;

    // Sign extend each lane partial before accumulating
    always_comb begin
        fwdTotal = '0;
        bwdTotal = '0;
        for (int k = 0; k < NumLanes; k++) begin
            fwdTotal = fwdTotal + contribT'(fwdParts[k]);
            bwdTotal = bwdTotal + contribT'(bwdParts[k]);
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            fwdContrib <= '0;
            bwdContrib <= '0;
        end else begin
            fwdContrib <= fwdTotal;
            bwdContrib <= bwdTotal;
        end
    end

endmodule

//--- design/contribLane.sv
module contribLane import batchPkg::*; #(
    parameter int laneIdx = 0
) (
    input  logic     clkDS,
    input  logic     rst,
    input  laneBitsT fwdBits,
    input  laneBitsT bwdBits,
    output laneT     fwdPart,
    output laneT     bwdPart
);

    laneT fwdSum;
    laneT bwdSum;

    // A control bit stands for +1 or -1 times its weight
    always_comb begin
        fwdSum = '0;
        bwdSum = '0;
        for (int b = 0; b < LaneBits; b++) begin
            if (fwdBits[b]) begin
                fwdSum = fwdSum + laneT'(fwdWeight[laneIdx*LaneBits + b]);
            end else begin
                fwdSum = fwdSum - laneT'(fwdWeight[laneIdx*LaneBits + b]);
            end
            if (bwdBits[b]) begin
                bwdSum = bwdSum + laneT'(bwdWeight[laneIdx*LaneBits + b]);
            end else begin
                bwdSum = bwdSum - laneT'(bwdWeight[laneIdx*LaneBits + b]);
            end
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            fwdPart <= '0;
            bwdPart <= '0;
        end else begin
            fwdPart <= fwdSum;
            bwdPart <= bwdSum;
        end
    end

endmodule

//--- design/sampleStore.sv
module sampleStore import batchPkg::*; (
    input  logic     clkDS,
    input  logic     rst,
    input  wordT     sampleWord,
    output wordT     fwdWord,
    output wordT     bwdWord,
    output posT      fwdPos,
    output posT      bwdPos,
    output batchIdxT fwdBatch,
    output batchIdxT bwdBatch,
    output logic     bwdFirst,
    output logic     fwdLive
);

    wordT     wordMem [NumSlots*BatchDepth];
    posT      wrPos;
    batchIdxT wrBatch;
    batchIdxT warmCnt;
    posT      bwdRdPos;
    batchIdxT bwdRdBatch;
    batchIdxT fwdRdBatch;
    logic     lastPos;

    assign lastPos = (wrPos == posT'(BatchDepth - 1));

    // Write position, write slot and warm-up batch count
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            wrPos   <= '0;
            wrBatch <= '0;
            warmCnt <= '0;
        end else begin
            if (lastPos) begin
                wrPos   <= '0;
                wrBatch <= wrBatch + 1'b1;
                if (warmCnt != batchIdxT'(WarmBatches)) begin
                    warmCnt <= warmCnt + 1'b1;
                end
            end else begin
                wrPos <= wrPos + 1'b1;
            end
        end
    end

    // Previous batch in reverse, three batches back in order
    assign bwdRdPos   = posT'(BatchDepth - 1) - wrPos;
    assign bwdRdBatch = wrBatch - 1'b1;
    assign fwdRdBatch = wrBatch - batchIdxT'(WarmBatches);

    // Ring memory, one write and two synchronous reads per cycle
    always_ff @(posedge clkDS) begin
        wordMem[{wrBatch, wrPos}] <= sampleWord;
        fwdWord <= wordMem[{fwdRdBatch, wrPos}];
        bwdWord <= wordMem[{bwdRdBatch, bwdRdPos}];
    end

    // Side-band registered so it lines up with the read data
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            fwdPos   <= '0;
            bwdPos   <= '0;
            fwdBatch <= '0;
            bwdBatch <= '0;
            bwdFirst <= 1'b0;
            fwdLive  <= 1'b0;
        end else begin
            fwdPos   <= wrPos;
            bwdPos   <= bwdRdPos;
            fwdBatch <= fwdRdBatch;
            bwdBatch <= bwdRdBatch;
            bwdFirst <= (wrPos == '0);
            fwdLive  <= (warmCnt == batchIdxT'(WarmBatches));
        end
    end

    // A read must never hit the batch that is being filled
    slotSeparate: assert property (
        @(posedge clkDS) disable iff (!rst)
        (fwdRdBatch != wrBatch) && (bwdRdBatch != wrBatch)
    ) else $error("sampleStore: read slot equals write slot %0d", wrBatch);

endmodule

//--- design/batchPkg.sv
package batchPkg;

    // Batch geometry and ring slots
    localparam int BatchDepth = 8;
    localparam int PosBits = $clog2(BatchDepth);
    localparam int NumSlots = 4;
    localparam int SlotBits = $clog2(NumSlots);
    // Forward path starts once three full batches are in the ring
    localparam int WarmBatches = 3;

    // Control word: 2 control bits times a downsampling ratio of 6
    localparam int WordBits = 12;
    localparam int LaneBits = 4;
    localparam int NumLanes = WordBits / LaneBits;

    // Arithmetic widths
    localparam int WeightBits = 6;
    localparam int LaneSumBits = 8;
    localparam int ContribBits = 10;
    localparam int StateBits = 16;
    localparam int OutBits = 12;
    localparam int OutMax = 2 ** (OutBits - 1) - 1;
    localparam int OutMin = -(2 ** (OutBits - 1));

    // Leak per step is state >>> DecayShift
    localparam int DecayShift = 2;

    // Lane register plus adder register
    localparam int PipeDelay = 2;
    // Ring, read, lane, adder, forward state and output registers
    localparam int LatencyCycles = 3 * BatchDepth + 5;

    typedef logic [PosBits-1:0] posT;
    typedef logic [SlotBits-1:0] batchIdxT;
    typedef logic [WordBits-1:0] wordT;
    typedef logic [LaneBits-1:0] laneBitsT;
    typedef logic signed [WeightBits-1:0] weightT;
    typedef logic signed [LaneSumBits-1:0] laneT;
    typedef logic signed [ContribBits-1:0] contribT;
    typedef logic signed [StateBits-1:0] stateT;
    typedef logic [OutBits-1:0] outT;

    // Forward weights, index is the bit position in the control word
    localparam weightT fwdWeight [WordBits] = '{
        6'sd31,
        6'sd30,
        6'sd30,
        6'sd29,
        6'sd29,
        6'sd28,
        6'sd28,
        6'sd27,
        6'sd27,
        6'sd26,
        6'sd26,
        6'sd25
    };

    // Backward weights, one tap has the opposite sign
    localparam weightT bwdWeight [WordBits] = '{
        6'sd29,
        6'sd27,
        6'sd26,
        6'sd24,
        6'sd23,
        6'sd21,
        6'sd20,
        6'sd18,
        6'sd17,
        6'sd15,
        6'sd14,
        -6'sd12
    };

endpackage
